//--- files.f
+incdir+.
dram_pkg.sv
dram_init_seq.sv
dram_access_fsm.sv
dram_cmd_encoder.sv
dram_ctrl_top.sv
tb_dram_ctrl.sv

//--- tb_dram_ctrl.sv
/*
 * testbench for the DDR4 single-rank command generator
 * pin timing is worked out from the interval rules, cycles counted from nRST release
 * six requests, three reads and three writes in shuffled order, fields from $urandom
 * all checking is done by assertions, the first failure ends the run
 */
`timescale 1ns/100ps
`include "dram_consts.svh"

module tb_dram_ctrl;

    localparam int NUM_REQ = 6;
    // init is under 100 cycles, one access under 40
    localparam int TIMEOUT = 2000;
    localparam int NEVER   = 32'h7fff_ffff;
    localparam int PWUP    = int'(`T_PWUP);
    localparam int XPR     = int'(`T_XPR);
    localparam int DLLK    = int'(`T_DLLK);
    localparam int MOD     = int'(`T_MOD);
    localparam int ZQINIT  = int'(`T_ZQINIT);
    localparam int RCD     = int'(`T_RCD);
    localparam int CL      = int'(`T_CL);
    localparam int CWL     = int'(`T_CWL);
    localparam int BURST   = int'(`T_BURST);
    localparam int WR_REC  = int'(`T_WR);
    localparam int RP      = int'(`T_RP);

    logic               CLK = 1'b0;
    logic               nRST;
    logic               req_valid;
    logic               req_write;
    logic [`BG_W-1:0]   req_bg;
    logic [`BA_W-1:0]   req_ba;
    logic [`ROW_W-1:0]  req_row;
    logic [`COL_W-1:0]  req_col;
    logic               req_ready, done, rd_en, wr_en;
    logic               reset_n, cke, cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14;
    logic [`BG_W-1:0]   bg;
    logic [`BA_W-1:0]   ba;
    logic [`ADDR_W-1:0] addr;

    // checker state, cycle k is the k-th rising edge after reset release
    int                 cyc = 0;
    int                 run_cyc = 0;
    int                 mr_seen = 0;
    bit                 zq_seen = 1'b0;
    int                 next_init = 2 * PWUP + XPR + 1;
    int                 ready_from = NEVER;
    int                 phase = 0;
    int                 exp_cyc = NEVER;
    bit                 win_write = 1'b0;
    int                 win_lo = NEVER;
    int                 win_hi = NEVER;
    int                 done_cyc = NEVER;
    int                 done_count = 0;
    logic               cur_write;
    logic [`BG_W-1:0]   cur_bg;
    logic [`BA_W-1:0]   cur_ba;
    logic [`ROW_W-1:0]  cur_row;
    logic [`COL_W-1:0]  cur_col;

    dram_ctrl_top uut (.*);

    always #2 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                                 test, expected, actual));
    endtask

    // mode-register loads as {bg, ba, addr}, DLL enable first
    function automatic logic [17:0] expected_mr(input int idx);
        case (idx)
            0:       return {2'd0, 2'd1, 14'h0001};
            1:       return {2'd0, 2'd3, 14'h0000};
            2:       return {2'd1, 2'd2, 14'h080F};
            3:       return {2'd1, 2'd1, 14'h0000};
            4:       return {2'd1, 2'd0, 14'h1000};
            5:       return {2'd0, 2'd2, 14'h0088};
            6:       return {2'd0, 2'd1, 14'h0001};
            default: return {2'd0, 2'd0, 14'h041D};
        endcase
    endfunction

    // pins back to a command, ACT whenever act_n is low
    function automatic dram_pkg::dram_cmd_e decode_pins(input logic [4:0] p);
        if (p[4]) return dram_pkg::DESEL;
        if (!p[3]) return dram_pkg::ACT;
        return dram_pkg::dram_cmd_e'(p);
    endfunction

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(posedge CLK) begin
        run_cyc++;
        if (run_cyc >= TIMEOUT) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // single cycle completion pulse
    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST) done |=> !done)
        else abort_run("done stayed high for more than one cycle");
    a_cke_with_reset: assert property (@(posedge CLK) disable iff (!nRST) cke == reset_n)
        else abort_run("cke and reset_n do not move together");
    a_one_window: assert property (@(posedge CLK) disable iff (!nRST) !(rd_en && wr_en))
        else abort_run("rd_en and wr_en are high in the same cycle");

    // sampled mid-cycle, all outputs settled
    always @(negedge CLK) begin : monitor
        dram_pkg::dram_cmd_e cmd;
        int len;
        cmd = decode_pins({cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14});
        check_value("reset_n", 32'(cyc >= 2 * PWUP), 32'(reset_n));
        check_value("cke", 32'(cyc >= 2 * PWUP), 32'(cke));
        check_value("req_ready", 32'(cyc >= ready_from), 32'(req_ready));
        // data windows and done
        check_value("rd_en", 32'(!win_write && cyc >= win_lo && cyc <= win_hi), 32'(rd_en));
        check_value("wr_en", 32'(win_write && cyc >= win_lo && cyc <= win_hi), 32'(wr_en));
        check_value("done", 32'(cyc == done_cyc), 32'(done));
        if (done) begin
            done_count++;
        end
        if (!zq_seen) begin
            // init walk, eight loads then calibration
            if (cmd != dram_pkg::DESEL) begin
                check_value("init cmd cycle", next_init, cyc);
                if (mr_seen < 8) begin
                    check_value("init mrs", 32'(dram_pkg::MRS), 32'(cmd));
                    check_value($sformatf("mr load %0d", mr_seen),
                                32'(expected_mr(mr_seen)), 32'({bg, ba, addr}));
                    next_init = cyc + ((mr_seen == 0) ? DLLK : MOD);
                    mr_seen++;
                end else begin
                    check_value("init zqcl", 32'(dram_pkg::ZQCL), 32'(cmd));
                    // long calibration, A10 set
                    check_value("zqcl addr", 32'h0400, 32'(addr));
                    zq_seen    = 1'b1;
                    // ready is combinational, the pins lag one cycle
                    ready_from = cyc + ZQINIT - 1;
                end
            end else if (cyc > next_init) begin
                abort_run("an init command did not reach the pins in time");
            end
        end else begin
            if (cmd != dram_pkg::DESEL) begin
                if (phase == 0) begin
                    abort_run("a command reached the pins with no request in flight");
                end else begin
                    check_value("access cmd cycle", exp_cyc, cyc);
                    check_value("bank group", 32'(cur_bg), 32'(bg));
                    check_value("bank", 32'(cur_ba), 32'(ba));
                    case (phase)
                        1: begin
                            check_value("act cmd", 32'(dram_pkg::ACT), 32'(cmd));
                            check_value("act row", 32'(cur_row),
                                        32'({ras_n_a16, cas_n_a15, we_n_a14, addr}));
                            exp_cyc = cyc + RCD;
                            phase   = 2;
                        end
                        2: begin
                            check_value("column cmd",
                                        32'(cur_write ? dram_pkg::WR : dram_pkg::RD), 32'(cmd));
                            check_value("column addr", 32'(cur_col), 32'(addr[`COL_W-1:0]));
                            check_value("column auto-precharge", 32'd0, 32'(addr[10]));
                            len = cur_write ? CWL + BURST + WR_REC : CL + BURST;
                            // strobes one cycle ahead of the pins
                            win_write = cur_write;
                            win_lo    = cur_write ? cyc + CWL - 1 : cyc + CL - 1;
                            win_hi    = win_lo + BURST - 1;
                            // last column cycle, one cycle ahead of the pins
                            done_cyc  = cyc + len - 2;
                            exp_cyc   = cyc + len;
                            phase     = 3;
                        end
                        default: begin
                            check_value("pre cmd", 32'(dram_pkg::PRE), 32'(cmd));
                            check_value("pre all-bank bit", 32'd0, 32'(addr[10]));
                            ready_from = cyc + RP - 1;
                            exp_cyc    = NEVER;
                            phase      = 0;
                        end
                    endcase
                end
            end else if (cyc > exp_cyc) begin
                abort_run("an access command did not reach the pins in time");
            end
            if (req_valid && req_ready) begin
                // ACTIVATE on the next edge, encoder adds one more
                phase      = 1;
                exp_cyc    = cyc + 2;
                ready_from = NEVER;
                cur_write  = req_write;
                cur_bg     = req_bg;
                cur_ba     = req_ba;
                cur_row    = req_row;
                cur_col    = req_col;
            end
        end
    end

    task automatic send_request(input logic write, input logic [31:0] rnd);
        @(posedge CLK);
        #1;
        req_valid = 1'b1;
        req_write = write;
        req_bg    = rnd[1:0];
        req_ba    = rnd[3:2];
        req_row   = rnd[20:4];
        req_col   = rnd[30:21];
        // ready seen mid-cycle holds through the next edge
        do
            @(negedge CLK);
        while (!req_ready);
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [NUM_REQ-1:0] kinds;
        int seed_ret;
        int j;
        logic tmp;
        nRST      = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_bg    = '0;
        req_ba    = '0;
        req_row   = '0;
        req_col   = '0;
        seed_ret  = $urandom(32'h7556);
        kinds     = 6'b111000;
        // shuffle read and write slots
        for (int i = NUM_REQ - 1; i > 0; i--) begin
            j        = int'($urandom_range(i, 0));
            tmp      = kinds[i];
            kinds[i] = kinds[j];
            kinds[j] = tmp;
        end
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int i = 0; i < NUM_REQ; i++) begin
            send_request(kinds[i], $urandom);
            repeat ($urandom_range(3, 0)) @(posedge CLK);
        end
        // last precharge finished once ready is back
        do
            @(negedge CLK);
        while (!req_ready || done_count < NUM_REQ);
        @(posedge CLK);
        if (done_count == NUM_REQ) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("FAILED done count: expected %0d, actual %0d",
                                NUM_REQ, done_count));
        end
    end

endmodule

//--- dram_ctrl_top.sv
/*
 * DDR4 single-rank command generator top
 * init sequencer, access sequencer and pin encoder, no logic of its own
 * only one request in flight, done and data windows lead the pins by a cycle
 */
`timescale 1ns/100ps
`include "dram_consts.svh"

module dram_ctrl_top (
    input  logic               CLK,
    input  logic               nRST,
    // request channel
    input  logic               req_valid,
    input  logic               req_write,
    input  logic [`BG_W-1:0]   req_bg,
    input  logic [`BA_W-1:0]   req_ba,
    input  logic [`ROW_W-1:0]  req_row,
    input  logic [`COL_W-1:0]  req_col,
    output logic               req_ready,
    output logic               done,
    output logic               rd_en,
    output logic               wr_en,
    // DDR4 pins
    output logic               reset_n,
    output logic               cke,
    output logic               cs_n,
    output logic               act_n,
    output logic               ras_n_a16,
    output logic               cas_n_a15,
    output logic               we_n_a14,
    output logic [`BG_W-1:0]   bg,
    output logic [`BA_W-1:0]   ba,
    output logic [`ADDR_W-1:0] addr
);

    dram_pkg::dram_cmd_e init_cmd;
    logic [`BG_W-1:0]    init_bg;
    logic [`BA_W-1:0]    init_ba;
    logic [`ADDR_W-1:0]  init_addr;
    logic                init_done;
    dram_pkg::dram_cmd_e acc_cmd;
    logic [`BG_W-1:0]    acc_bg;
    logic [`BA_W-1:0]    acc_ba;
    logic [`ROW_W-1:0]   acc_row;
    logic [`COL_W-1:0]   acc_col;

    dram_init_seq u_init (
        .CLK(CLK), .nRST(nRST),
        .init_cmd(init_cmd), .init_bg(init_bg), .init_ba(init_ba), .init_addr(init_addr),
        .reset_n(reset_n), .cke(cke), .init_done(init_done)
    );

    dram_access_fsm u_access (
        .CLK(CLK), .nRST(nRST), .init_done(init_done),
        .req_valid(req_valid), .req_write(req_write), .req_bg(req_bg), .req_ba(req_ba),
        .req_row(req_row), .req_col(req_col), .req_ready(req_ready),
        .acc_cmd(acc_cmd), .acc_bg(acc_bg), .acc_ba(acc_ba),
        .acc_row(acc_row), .acc_col(acc_col),
        .rd_en(rd_en), .wr_en(wr_en), .done(done)
    );

    dram_cmd_encoder u_enc (
        .CLK(CLK), .nRST(nRST),
        .init_cmd(init_cmd), .init_bg(init_bg), .init_ba(init_ba), .init_addr(init_addr),
        .acc_cmd(acc_cmd), .acc_bg(acc_bg), .acc_ba(acc_ba),
        .acc_row(acc_row), .acc_col(acc_col),
        .cs_n(cs_n), .act_n(act_n), .ras_n_a16(ras_n_a16), .cas_n_a15(cas_n_a15),
        .we_n_a14(we_n_a14), .bg(bg), .ba(ba), .addr(addr)
    );

endmodule

//--- dram_cmd_encoder.sv
/*
 * merges init and access command sources and registers the DDR4 command pins
 * access source wins whenever it is not DESEL, init source otherwise
 * pins follow the selected source one cycle later, reset value is DESEL
 * RD and WR go out with auto-precharge off and no burst chop
 */
`timescale 1ns/100ps
`include "dram_consts.svh"

module dram_cmd_encoder (
    input  logic                CLK,
    input  logic                nRST,
    input  dram_pkg::dram_cmd_e init_cmd,
    input  logic [`BG_W-1:0]    init_bg,
    input  logic [`BA_W-1:0]    init_ba,
    input  logic [`ADDR_W-1:0]  init_addr,
    input  dram_pkg::dram_cmd_e acc_cmd,
    input  logic [`BG_W-1:0]    acc_bg,
    input  logic [`BA_W-1:0]    acc_ba,
    input  logic [`ROW_W-1:0]   acc_row,
    input  logic [`COL_W-1:0]   acc_col,
    output logic                cs_n,
    output logic                act_n,
    output logic                ras_n_a16,
    output logic                cas_n_a15,
    output logic                we_n_a14,
    output logic [`BG_W-1:0]    bg,
    output logic [`BA_W-1:0]    ba,
    output logic [`ADDR_W-1:0]  addr
);

    logic                sel_acc;
    logic [4:0]          pins_d;
    logic [`BG_W-1:0]    bg_d;
    logic [`BA_W-1:0]    ba_d;
    logic [`ADDR_W-1:0]  addr_d;

    assign sel_acc = (acc_cmd != dram_pkg::DESEL);

    always_comb begin
        pins_d = init_cmd;
        bg_d   = init_bg;
        ba_d   = init_ba;
        addr_d = init_addr;
        if (sel_acc) begin
            pins_d = acc_cmd;
            bg_d   = acc_bg;
            ba_d   = acc_ba;
            addr_d = '0;
            case (acc_cmd)
                dram_pkg::ACT: begin
                    // upper row bits ride on ras/cas/we
                    pins_d = {acc_cmd[4:3], acc_row[16:14]};
                    addr_d = acc_row[13:0];
                end
                dram_pkg::RD,
                dram_pkg::WR: begin
                    addr_d[`COL_W-1:0] = acc_col;
                    // A12 high means BL8 on the fly
                    addr_d[12] = 1'b1;
                    // A10 low, no auto-precharge
                    addr_d[10] = 1'b0;
                end
                // single-bank precharge, A10 stays low
                default: addr_d = '0;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} <= dram_pkg::DESEL;
            bg   <= '0;
            ba   <= '0;
            addr <= '0;
        end else begin
            {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} <= pins_d;
            bg   <= bg_d;
            ba   <= ba_d;
            addr <= addr_d;
        end
    end

    // init and access phases never overlap
    a_single_source: assert property (@(posedge CLK) disable iff (!nRST)
        !(sel_acc && init_cmd != dram_pkg::DESEL));

endmodule

//--- dram_access_fsm.sv
/*
 * closed-page access sequencer, one request in flight at a time
 * ACT, then RD or WR, then PRE, no look-ahead and no refresh
 * req_ready only in IDLE once init is done, requester must hold fields until accepted
 * rd_en, wr_en and done are combinational and lead the command pins by one cycle
 */
`timescale 1ns/100ps
`include "dram_consts.svh"

module dram_access_fsm (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                init_done,
    input  logic                req_valid,
    input  logic                req_write,
    input  logic [`BG_W-1:0]    req_bg,
    input  logic [`BA_W-1:0]    req_ba,
    input  logic [`ROW_W-1:0]   req_row,
    input  logic [`COL_W-1:0]   req_col,
    output logic                req_ready,
    output dram_pkg::dram_cmd_e acc_cmd,
    output logic [`BG_W-1:0]    acc_bg,
    output logic [`BA_W-1:0]    acc_ba,
    output logic [`ROW_W-1:0]   acc_row,
    output logic [`COL_W-1:0]   acc_col,
    output logic                rd_en,
    output logic                wr_en,
    output logic                done
);

    // column state lengths
    localparam logic [`CNT_W-1:0] RD_LEN = `T_CL + `T_BURST;
    localparam logic [`CNT_W-1:0] WR_LEN = `T_CWL + `T_BURST + `T_WR;
    localparam logic [`CNT_W-1:0] WR_END = `T_CWL + `T_BURST;

    dram_pkg::access_state_e state, state_n;
    logic [`CNT_W-1:0]       cnt;
    logic [`CNT_W-1:0]       interval;
    logic                    last;
    logic                    first;
    logic                    accept;

    // latched request, payload only
    logic                    write_q;
    logic [`BG_W-1:0]        bg_q;
    logic [`BA_W-1:0]        ba_q;
    logic [`ROW_W-1:0]       row_q;
    logic [`COL_W-1:0]       col_q;

    assign req_ready = init_done && (state == dram_pkg::IDLE);
    assign accept    = req_valid && req_ready;

    always_comb begin
        case (state)
            dram_pkg::ACTIVATE:  interval = `T_RCD;
            dram_pkg::COL_READ:  interval = RD_LEN;
            dram_pkg::COL_WRITE: interval = WR_LEN;
            dram_pkg::PRECHARGE: interval = `T_RP;
            default:             interval = '0;
        endcase
    end

    assign first = (cnt == '0);
    assign last  = (state != dram_pkg::IDLE) && (cnt == interval - 1'b1);

    // next state
    always_comb begin
        state_n = state;
        case (state)
            dram_pkg::IDLE: begin
                if (accept) begin
                    state_n = dram_pkg::ACTIVATE;
                end
            end
            dram_pkg::ACTIVATE: begin
                if (last) begin
                    state_n = write_q ? dram_pkg::COL_WRITE : dram_pkg::COL_READ;
                end
            end
            dram_pkg::COL_READ,
            dram_pkg::COL_WRITE: begin
                if (last) begin
                    state_n = dram_pkg::PRECHARGE;
                end
            end
            dram_pkg::PRECHARGE: begin
                if (last) begin
                    state_n = dram_pkg::IDLE;
                end
            end
            default: state_n = dram_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dram_pkg::IDLE;
            cnt   <= '0;
        end else begin
            state <= state_n;
            // counter held at zero while idle
            if (last || state == dram_pkg::IDLE) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // capture on the accepting edge
    always_ff @(posedge CLK) begin
        if (accept) begin
            write_q <= req_write;
            bg_q    <= req_bg;
            ba_q    <= req_ba;
            row_q   <= req_row;
            col_q   <= req_col;
        end
    end

    // fields stay valid for the whole access
    assign acc_bg  = bg_q;
    assign acc_ba  = ba_q;
    assign acc_row = row_q;
    assign acc_col = col_q;

    always_comb begin
        acc_cmd = dram_pkg::DESEL;
        if (first) begin
            case (state)
                dram_pkg::ACTIVATE:  acc_cmd = dram_pkg::ACT;
                dram_pkg::COL_READ:  acc_cmd = dram_pkg::RD;
                dram_pkg::COL_WRITE: acc_cmd = dram_pkg::WR;
                dram_pkg::PRECHARGE: acc_cmd = dram_pkg::PRE;
                default:             acc_cmd = dram_pkg::DESEL;
            endcase
        end
    end

    // read data in the last burst cycles of the column state
    assign rd_en = (state == dram_pkg::COL_READ) && (cnt >= `T_CL);
    // write data after write latency, then recovery
    assign wr_en = (state == dram_pkg::COL_WRITE) && (cnt >= `T_CWL) && (cnt < WR_END);
    assign done  = last && (state == dram_pkg::COL_READ || state == dram_pkg::COL_WRITE);

    // no request taken while the device is still initialising
    a_ready_after_init: assert property (@(posedge CLK) disable iff (!nRST)
        !init_done |-> !req_ready);

    // a single burst window at a time
    a_one_window: assert property (@(posedge CLK) disable iff (!nRST)
        !(rd_en && wr_en));

endmodule

//--- dram_init_seq.sv
/*
 * DDR4 power-up and initialisation sequencer for a single rank
 * runs once after nRST, then holds init_done high until the next reset
 * every state lasts its full interval, a command shows on its first cycle only
 * reset_n and cke are decoded from state and go straight to the pins
 */
`timescale 1ns/100ps
`include "dram_consts.svh"

module dram_init_seq (
    input  logic                CLK,
    input  logic                nRST,
    output dram_pkg::dram_cmd_e init_cmd,
    output logic [`BG_W-1:0]    init_bg,
    output logic [`BA_W-1:0]    init_ba,
    output logic [`ADDR_W-1:0]  init_addr,
    output logic                reset_n,
    output logic                cke,
    output logic                init_done
);

    // load values in issue order, entry 0 at the low end
    localparam dram_pkg::mr_table_t MR_TABLE = {
        `MR_LOAD_7, `MR_LOAD_6, `MR_LOAD_5, `MR_LOAD_4,
        `MR_LOAD_3, `MR_LOAD_2, `MR_LOAD_1, `MR_LOAD_0
    };

    dram_pkg::init_state_e state, state_n;
    logic [`CNT_W-1:0]     cnt;
    logic [`CNT_W-1:0]     interval;
    logic [2:0]            load_idx;
    logic                  step;
    logic                  first;
    dram_pkg::mr_entry_t   cur_mr;

    // length of the current state
    always_comb begin
        case (state)
            dram_pkg::PWR_RAMP,
            dram_pkg::RESET_HOLD: interval = `T_PWUP;
            dram_pkg::EXIT_WAIT:  interval = `T_XPR;
            // dll enable needs the lock time
            dram_pkg::LOAD_MR:    interval = (load_idx == 3'd0) ? `T_DLLK : `T_MOD;
            dram_pkg::ZQ_CAL:     interval = `T_ZQINIT;
            default:              interval = '0;
        endcase
    end

    assign first = (cnt == '0);
    assign step  = (state != dram_pkg::INIT_DONE) && (cnt == interval - 1'b1);

    // next state
    always_comb begin
        state_n = state;
        if (step) begin
            case (state)
                dram_pkg::PWR_RAMP:   state_n = dram_pkg::RESET_HOLD;
                dram_pkg::RESET_HOLD: state_n = dram_pkg::EXIT_WAIT;
                dram_pkg::EXIT_WAIT:  state_n = dram_pkg::LOAD_MR;
                dram_pkg::LOAD_MR: begin
                    // stay here until the last load has had its interval
                    if (load_idx == 3'(`MR_LOADS - 1)) begin
                        state_n = dram_pkg::ZQ_CAL;
                    end
                end
                dram_pkg::ZQ_CAL:     state_n = dram_pkg::INIT_DONE;
                default:              state_n = state;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= dram_pkg::PWR_RAMP;
            cnt      <= '0;
            load_idx <= '0;
        end else begin
            state <= state_n;
            // interval counter restarts on every step
            if (step) begin
                cnt <= '0;
            end else if (state != dram_pkg::INIT_DONE) begin
                cnt <= cnt + 1'b1;
            end
            if (step && state == dram_pkg::LOAD_MR) begin
                load_idx <= load_idx + 3'd1;
            end
        end
    end

    assign cur_mr = MR_TABLE[load_idx];

    // command on first cycle of a state only
    always_comb begin
        init_cmd  = dram_pkg::DESEL;
        init_bg   = '0;
        init_ba   = '0;
        init_addr = '0;
        if (first && state == dram_pkg::LOAD_MR) begin
            init_cmd  = dram_pkg::MRS;
            init_bg   = cur_mr.bg;
            init_ba   = cur_mr.ba;
            init_addr = cur_mr.addr;
        end else if (first && state == dram_pkg::ZQ_CAL) begin
            init_cmd  = dram_pkg::ZQCL;
            init_addr = `ZQ_ADDR;
        end
    end

    // device held in reset through ramp and hold
    assign reset_n   = (state != dram_pkg::PWR_RAMP) && (state != dram_pkg::RESET_HOLD);
    assign cke       = reset_n;
    assign init_done = (state == dram_pkg::INIT_DONE);

    // init source only ever issues mode loads and calibration
    a_init_cmd_legal: assert property (@(posedge CLK) disable iff (!nRST)
        init_cmd inside {dram_pkg::DESEL, dram_pkg::MRS, dram_pkg::ZQCL});

endmodule

//--- dram_pkg.sv
/*
 * types shared by the DDR4 command generator
 * command encoding is {CS_n, ACT_n, RAS_n, CAS_n, WE_n}
 * ACT carries only its top two bits here, the encoder fills in row bits 16 to 14
 */
`include "dram_consts.svh"

package dram_pkg;

    // command pin patterns
    typedef enum logic [4:0] {
        DESEL   = 5'b11111,
        NOP_CMD = 5'b01111,
        MRS     = 5'b01000,
        ZQCL    = 5'b01110,
        // low three bits replaced by row address
        ACT     = 5'b00000,
        RD      = 5'b01101,
        WR      = 5'b01100,
        PRE     = 5'b01010
    } dram_cmd_e;

    // power-up walk
    typedef enum logic [2:0] {
        PWR_RAMP,
        RESET_HOLD,
        EXIT_WAIT,
        LOAD_MR,
        ZQ_CAL,
        INIT_DONE
    } init_state_e;

    // closed-page access walk
    typedef enum logic [2:0] {
        IDLE,
        ACTIVATE,
        COL_READ,
        COL_WRITE,
        PRECHARGE
    } access_state_e;

    // one mode-register load
    typedef struct packed {
        logic [`BG_W-1:0]   bg;
        logic [`BA_W-1:0]   ba;
        logic [`ADDR_W-1:0] addr;
    } mr_entry_t;

    // all loads, index 0 issued first
    typedef mr_entry_t [`MR_LOADS-1:0] mr_table_t;

endpackage

//--- dram_consts.svh
/*
 * shared widths, timing counts and mode-register values for the DDR4 command generator
 * timing counts are shortened for simulation and are not real DDR4 speed-bin values
 * every interval is a count of controller clock cycles, 12 bits wide
 * mode-register loads are {bg, ba, addr} in issue order, load 0 enables the DLL
 */
`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// address widths
`define ROW_W       17
`define COL_W       10
`define ADDR_W      14
`define BG_W        2
`define BA_W        2
`define CNT_W       12

// power-up and init intervals
`define T_PWUP      12'd20
`define T_XPR       12'd10
`define T_DLLK      12'd8
`define T_MOD       12'd4
`define T_ZQINIT    12'd8

// access intervals
`define T_RCD       12'd4
`define T_CL        12'd5
`define T_CWL       12'd4
`define T_BURST     12'd4
`define T_WR        12'd6
`define T_RP        12'd4

// mode-register loads as {bg, ba, addr}
`define MR_LOADS    8
`define MR_LOAD_0   {2'd0, 2'd1, 14'h0001}
`define MR_LOAD_1   {2'd0, 2'd3, 14'h0000}
`define MR_LOAD_2   {2'd1, 2'd2, 14'h080F}
`define MR_LOAD_3   {2'd1, 2'd1, 14'h0000}
`define MR_LOAD_4   {2'd1, 2'd0, 14'h1000}
`define MR_LOAD_5   {2'd0, 2'd2, 14'h0088}
`define MR_LOAD_6   {2'd0, 2'd1, 14'h0001}
`define MR_LOAD_7   {2'd0, 2'd0, 14'h041D}

// long ZQ calibration, A10 high
`define ZQ_ADDR     14'h0400

`endif
